// File: include/sys_defines.svh
// Shared widths, host command codes and reset values for the housekeeping core
// Default video timing is 1280x720 CEA, totals 1650 x 750
// Debounce period counts FPGA_CLK2_50 cycles, about 2 ms at 50 MHz
`ifndef SYS_DEFINES_SVH
`define SYS_DEFINES_SVH

// ==================================================
// Widths
// ==================================================
`define SYS_TIMING_W 12
`define SYS_IO_W 16

// Host command codes, low byte of the first word in a frame
`define SYS_CMD_CFG 8'h01
`define SYS_CMD_TIMING 8'h20
`define SYS_CMD_LED 8'h25

// ==================================================
// 1280x720 CEA timing
// ==================================================
`define SYS_DEF_WIDTH 12'd1280
`define SYS_DEF_HFP 12'd110
`define SYS_DEF_HS 12'd40
`define SYS_DEF_HBP 12'd220
`define SYS_DEF_HEIGHT 12'd720
`define SYS_DEF_VFP 12'd5
`define SYS_DEF_VS 12'd5
`define SYS_DEF_VBP 12'd20

// Cycles between debounce ticks, minus one
`define SYS_DEBOUNCE_DIV 100000

`endif

// File: logic/sys_pkg.sv
// Shared types of the housekeeping core
// Timing index order matches the word order of a timing frame
`include "sys_defines.svh"

package sys_pkg;

	typedef logic [7:0] cmd_t;
	typedef logic [`SYS_TIMING_W-1:0] timing_t;
	typedef logic [`SYS_IO_W-1:0] io_word_t;
	typedef logic [`SYS_IO_W-1:0] cfg_t;
	typedef logic [1:0] amix_t;

	// Order of the eight values in a timing frame
	typedef enum logic [2:0] {
		TIM_WIDTH,
		TIM_HFP,
		TIM_HS,
		TIM_HBP,
		TIM_HEIGHT,
		TIM_VFP,
		TIM_VS,
		TIM_VBP
	} timing_idx_t;

	// Upper byte selects the override, lower byte is the LED state
	typedef struct packed {
		logic [7:0] mask;
		logic [7:0] state;
	} led_ovr_t;

	// Button sample history, newest sample in bit 0
	typedef logic [7:0] deb_hist_t;

	// Host reset control codes
	typedef logic [1:0] ctl_code_t;
	localparam ctl_code_t CTL_ARM = 2'd0;
	localparam ctl_code_t CTL_SET = 2'd1;
	localparam ctl_code_t CTL_CLEAR = 2'd2;

endpackage

// File: logic/hps_cmd_decoder.sv
// The first strobe of an io_uio frame is the command byte
// Each later strobe is a data word and gives one registered write strobe
// Words past the eighth of a timing frame are dropped
// Strobes are single cycle with no back-pressure
`include "sys_defines.svh"

module hps_cmd_decoder
	import sys_pkg::*;
(
	input  logic        FPGA_CLK2_50,
	input  logic        resetd,
	input  logic        io_uio,
	input  logic        io_strobe,
	input  io_word_t    io_din,
	output cfg_t        cfg,
	output logic        cfg_got,
	output logic        tim_we,
	output timing_idx_t tim_idx,
	output timing_t     tim_data,
	output logic        led_we,
	output led_ovr_t    led_data
);

	logic       has_cmd;
	cmd_t       cmd;
	// Bit 3 set means all eight timing values were taken
	logic [3:0] word_cnt;

	// ==================================================
	// Frame state and write strobes
	// ==================================================
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cmd <= '0;
			word_cnt <= '0;
			cfg <= '0;
			cfg_got <= 1'b0;
			tim_we <= 1'b0;
			tim_idx <= TIM_WIDTH;
			tim_data <= '0;
			led_we <= 1'b0;
			led_data <= '0;
		end else begin
			tim_we <= 1'b0;
			led_we <= 1'b0;

			if (!io_uio) begin
				// Command forgotten while idle between frames
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
					cmd <= io_din[7:0];
					word_cnt <= '0;
				end else begin
					case (cmd)
						`SYS_CMD_CFG: begin
							cfg <= io_din;
							cfg_got <= 1'b1;
						end
						`SYS_CMD_TIMING: begin
							if (!word_cnt[3]) begin
								tim_we <= 1'b1;
								tim_idx <= timing_idx_t'(word_cnt[2:0]);
								tim_data <= io_din[`SYS_TIMING_W-1:0];
								word_cnt <= word_cnt + 4'd1;
							end
						end
						`SYS_CMD_LED: begin
							led_we <= 1'b1;
							led_data <= io_din;
						end
						default: begin
							// Unknown commands are swallowed
						end
					endcase
				end
			end
		end
	end

	// ==================================================
	// Checks
	// ==================================================
	// Only one peer is written per host word
	a_one_peer_write: assert property (
		@(posedge FPGA_CLK2_50) disable iff (resetd)
		!(tim_we && led_we)
	) else $error("timing and LED write strobes high together");

endmodule

// File: logic/video_timing_regs.sv
// Eight video timing values, reset to 1280x720 CEA
// Totals are registered together with the value write, so they
// never lag the stored values. Sums wrap at the timing width
`include "sys_defines.svh"

module video_timing_regs
	import sys_pkg::*;
(
	input  logic        FPGA_CLK2_50,
	input  logic        resetd,
	input  logic        tim_we,
	input  timing_idx_t tim_idx,
	input  timing_t     tim_data,
	output timing_t     width,
	output timing_t     height,
	output timing_t     h_total,
	output timing_t     v_total
);

	localparam timing_t TIM_DEF [8] = '{
		`SYS_DEF_WIDTH, `SYS_DEF_HFP, `SYS_DEF_HS, `SYS_DEF_HBP,
		`SYS_DEF_HEIGHT, `SYS_DEF_VFP, `SYS_DEF_VS, `SYS_DEF_VBP
	};

	timing_t tim_val [8];
	// Values as they will be after this cycle's write
	timing_t tim_nxt [8];

	always_comb begin
		for (int i = 0; i < 8; i++) begin
			tim_nxt[i] = (tim_we && tim_idx == timing_idx_t'(i)) ? tim_data : tim_val[i];
		end
	end

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			for (int i = 0; i < 8; i++) begin
				tim_val[i] <= TIM_DEF[i];
			end
			h_total <= TIM_DEF[0] + TIM_DEF[1] + TIM_DEF[2] + TIM_DEF[3];
			v_total <= TIM_DEF[4] + TIM_DEF[5] + TIM_DEF[6] + TIM_DEF[7];
		end else begin
			if (tim_we) begin
				tim_val[tim_idx] <= tim_data;
			end
			h_total <= tim_nxt[TIM_WIDTH] + tim_nxt[TIM_HFP] + tim_nxt[TIM_HS]
				+ tim_nxt[TIM_HBP];
			v_total <= tim_nxt[TIM_HEIGHT] + tim_nxt[TIM_VFP] + tim_nxt[TIM_VS]
				+ tim_nxt[TIM_VBP];
		end
	end

	assign width = tim_val[TIM_WIDTH];
	assign height = tim_val[TIM_HEIGHT];

endmodule

// File: logic/button_debounce.sv
// Debounces the user and OSD buttons merged with one board key each
// Inputs are active low and sampled on a tick every DEBOUNCE_DIV+1 cycles
// An output moves on the tick after eight agreeing samples
`include "sys_defines.svh"

module button_debounce
	import sys_pkg::*;
#(
	parameter int DEBOUNCE_DIV = `SYS_DEBOUNCE_DIV
) (
	input  logic       FPGA_CLK2_50,
	input  logic       resetd,
	input  logic       btn_user_n,
	input  logic       btn_osd_n,
	input  logic [1:0] key_n,
	output logic       btn_user,
	output logic       btn_osd
);

	localparam int DIV_W = (DEBOUNCE_DIV > 0) ? $clog2(DEBOUNCE_DIV + 1) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	// Channel 0 is user and channel 1 is OSD
	logic [1:0]       press_q;
	deb_hist_t        hist [2];
	logic [1:0]       btn_q;

	// ==================================================
	// Tick divider
	// ==================================================
	assign tick = (div_cnt == DIV_W'(DEBOUNCE_DIV));

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
		end
	end

	// ==================================================
	// Sample history and outputs
	// ==================================================
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			press_q <= '0;
			hist[0] <= '0;
			hist[1] <= '0;
			btn_q <= '0;
		end else begin
			// Pressed when either source is low
			press_q <= {~(btn_osd_n & key_n[0]), ~(btn_user_n & key_n[1])};
			if (tick) begin
				for (int i = 0; i < 2; i++) begin
					hist[i] <= {hist[i][6:0], press_q[i]};
					if (&hist[i]) begin
						btn_q[i] <= 1'b1;
					end else if (~|hist[i]) begin
						btn_q[i] <= 1'b0;
					end
				end
			end
		end
	end

	assign btn_user = btn_q[0];
	assign btn_osd = btn_q[1];

	a_div_range: assert property (
		@(posedge FPGA_CLK2_50) disable iff (resetd)
		div_cnt <= DIV_W'(DEBOUNCE_DIV)
	) else $error("debounce divider out of range");

endmodule

// File: logic/reset_control.sv
// Reset request latch for the core
// Host code 1 or a low reset button sets it; clearing needs code 0
// followed by code 2 on the next cycle. Set wins over clear
module reset_control
	import sys_pkg::*;
(
	input  logic      FPGA_CLK2_50,
	input  logic      resetd,
	input  ctl_code_t ctl_code,
	input  logic      btn_reset_n,
	output logic      reset_req
);

	ctl_code_t ctl_d;
	ctl_code_t ctl_d2;
	logic      btn_reset_q;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			ctl_d <= CTL_ARM;
			ctl_d2 <= CTL_ARM;
			btn_reset_q <= 1'b1;
			reset_req <= 1'b0;
		end else begin
			ctl_d <= ctl_code;
			ctl_d2 <= ctl_d;
			btn_reset_q <= btn_reset_n;

			if (ctl_d == CTL_SET || !btn_reset_q) begin
				reset_req <= 1'b1;
			end else if (ctl_d == CTL_CLEAR && ctl_d2 == CTL_ARM) begin
				// Two step release guards against a stray code
				reset_req <= 1'b0;
			end
		end
	end

endmodule

// File: logic/led_control.sv
// Status and board LEDs
// Status LEDs follow the core directly, board LEDs take the host
// override per bit where the mask is set
module led_control
	import sys_pkg::*;
(
	input  logic       FPGA_CLK2_50,
	input  logic       resetd,
	input  logic       led_we,
	input  led_ovr_t   led_data,
	input  logic       led_user,
	input  logic [1:0] led_power,
	input  logic [1:0] led_disk,
	output logic       led_power_on,
	output logic       led_hdd_on,
	output logic       led_user_on,
	output logic [7:0] led
);

	led_ovr_t   ovr;
	logic [7:0] led_def;

	// Host override, mask clear after reset
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			ovr <= '0;
		end else if (led_we) begin
			ovr <= led_data;
		end
	end

	// Power is on unless the core takes control of it
	assign led_power_on = led_power[1] ? led_power[0] : 1'b1;
	assign led_hdd_on = led_disk[0];
	assign led_user_on = led_user;

	// Default board pattern mirrors the status LEDs
	assign led_def = {3'b000, led_power_on, 1'b0, led_hdd_on, 1'b0, led_user_on};

	assign led = (ovr.mask & ovr.state) | (~ovr.mask & led_def);

endmodule

// File: logic/audio_mixer.sv
// Stereo blend by amix, one cycle latency, a new pair every cycle
// audio_s selects arithmetic (signed) or logical (unsigned) shifts
// Sums wrap at 16 bits
module audio_mixer
	import sys_pkg::*;
(
	input  logic        FPGA_CLK2_50,
	input  logic        resetd,
	input  logic [15:0] audio_l,
	input  logic [15:0] audio_r,
	input  logic        audio_s,
	input  amix_t       amix,
	output logic [15:0] mix_l,
	output logic [15:0] mix_r
);

	// Right shift honouring the sample format
	function automatic logic [15:0] shr(input logic [15:0] v, input int unsigned n,
			input logic s);
		if (s) begin
			return 16'($signed(v) >>> n);
		end
		return v >> n;
	endfunction

	// Own channel x with a share of the other channel y
	function automatic logic [15:0] blend(input logic [15:0] x, input logic [15:0] y,
			input amix_t lvl, input logic s);
		logic [15:0] res;
		case (lvl)
			2'd0: res = x;
			2'd1: res = x - shr(x, 3, s) + shr(y, 3, s);
			2'd2: res = x - shr(x, 2, s) + shr(y, 2, s);
			default: res = shr(x, 1, s) + shr(y, 1, s);
		endcase
		return res;
	endfunction

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			mix_l <= '0;
			mix_r <= '0;
		end else begin
			mix_l <= blend(audio_l, audio_r, amix, audio_s);
			mix_r <= blend(audio_r, audio_l, amix, audio_s);
		end
	end

endmodule

// File: logic/sys_top.sv
// Housekeeping core top, single clock FPGA_CLK2_50
// Host words enter as io_uio frames of single-cycle strobes
// All buttons and keys are active low
`include "sys_defines.svh"

module sys_top
	import sys_pkg::*;
#(
	parameter int DEBOUNCE_DIV = `SYS_DEBOUNCE_DIV
) (
	input  logic        FPGA_CLK2_50,
	input  logic        resetd,

	// Host
	input  logic        io_uio,
	input  logic        io_strobe,
	input  io_word_t    io_din,
	input  ctl_code_t   ctl_code,
	output cfg_t        cfg,
	output logic        cfg_got,

	// Video timing
	output timing_t     width,
	output timing_t     height,
	output timing_t     h_total,
	output timing_t     v_total,

	// Buttons and keys
	input  logic        btn_user_n,
	input  logic        btn_osd_n,
	input  logic [1:0]  key_n,
	input  logic        btn_reset_n,
	output logic        btn_user,
	output logic        btn_osd,
	output logic        reset_req,

	// LEDs
	input  logic        led_user,
	input  logic [1:0]  led_power,
	input  logic [1:0]  led_disk,
	output logic        led_power_on,
	output logic        led_hdd_on,
	output logic        led_user_on,
	output logic [7:0]  led,

	// Audio
	input  logic [15:0] audio_l,
	input  logic [15:0] audio_r,
	input  logic        audio_s,
	input  amix_t       amix,
	output logic [15:0] mix_l,
	output logic [15:0] mix_r
);

	// ==================================================
	// Decoder write strobes
	// ==================================================
	logic        tim_we;
	timing_idx_t tim_idx;
	timing_t     tim_data;
	logic        led_we;
	led_ovr_t    led_data;

	hps_cmd_decoder i_hps_cmd_decoder (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.io_uio       (io_uio),
		.io_strobe    (io_strobe),
		.io_din       (io_din),
		.cfg          (cfg),
		.cfg_got      (cfg_got),
		.tim_we       (tim_we),
		.tim_idx      (tim_idx),
		.tim_data     (tim_data),
		.led_we       (led_we),
		.led_data     (led_data)
	);

	video_timing_regs i_video_timing_regs (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.tim_we       (tim_we),
		.tim_idx      (tim_idx),
		.tim_data     (tim_data),
		.width        (width),
		.height       (height),
		.h_total      (h_total),
		.v_total      (v_total)
	);

	button_debounce #(
		.DEBOUNCE_DIV (DEBOUNCE_DIV)
	) i_button_debounce (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.btn_user_n   (btn_user_n),
		.btn_osd_n    (btn_osd_n),
		.key_n        (key_n),
		.btn_user     (btn_user),
		.btn_osd      (btn_osd)
	);

	reset_control i_reset_control (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.ctl_code     (ctl_code),
		.btn_reset_n  (btn_reset_n),
		.reset_req    (reset_req)
	);

	led_control i_led_control (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.led_we       (led_we),
		.led_data     (led_data),
		.led_user     (led_user),
		.led_power    (led_power),
		.led_disk     (led_disk),
		.led_power_on (led_power_on),
		.led_hdd_on   (led_hdd_on),
		.led_user_on  (led_user_on),
		.led          (led)
	);

	audio_mixer i_audio_mixer (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.audio_s      (audio_s),
		.amix         (amix),
		.mix_l        (mix_l),
		.mix_r        (mix_r)
	);

endmodule

// File: tests/sys_top_tb.sv
// Directed testbench for the housekeeping core top level
// DEBOUNCE_DIV is cut to 15 so a debounced press settles within 146 cycles
// Inputs change on the rising edge, outputs are sampled on the falling edge
module sys_top_tb
	import sys_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DEB_DIV = 15;
	localparam int DEB_BOUND = 9 * (DEB_DIV + 1) + 2;
	// Held for six ticks at most, so never eight pressed samples
	localparam int GLITCH_LEN = 6 * (DEB_DIV + 1);
	// The tests take about 2000 cycles
	localparam int MAX_CYCLES = 6000;
	localparam io_word_t TIM_WORDS [10] = '{
		16'd1920, 16'd88, 16'd44, 16'd148, 16'd1080, 16'd4, 16'd5, 16'd36,
		16'h0abc, 16'h0123
	};

	logic        FPGA_CLK2_50;
	logic        resetd;
	logic        io_uio;
	logic        io_strobe;
	io_word_t    io_din;
	ctl_code_t   ctl_code;
	cfg_t        cfg;
	logic        cfg_got;
	timing_t     width, height, h_total, v_total;
	logic        btn_user_n, btn_osd_n, btn_reset_n;
	logic [1:0]  key_n;
	logic        btn_user, btn_osd, reset_req;
	logic        led_user;
	logic [1:0]  led_power, led_disk;
	logic        led_power_on, led_hdd_on, led_user_on;
	logic [7:0]  led;
	logic [15:0] audio_l, audio_r, mix_l, mix_r;
	logic        audio_s;
	amix_t       amix;

	logic [31:0] lfsr = 32'hc90e;
	io_word_t    frame_buf [16];
	int          cycles = 0;
	int          err_count = 0;
	int          first_err = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	sys_top #(
		.DEBOUNCE_DIV (DEB_DIV)
	) i_sys_top (.*);

	initial begin
		FPGA_CLK2_50 = 1'b0;
		forever #10 FPGA_CLK2_50 = ~FPGA_CLK2_50;
	end

	always @(posedge FPGA_CLK2_50) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ==================================================
	// Helpers
	// ==================================================
	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic value_error(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		err_count++;
	endtask

	task automatic log_problem(input string what);
		$display("Error: %s", what);
		err_count++;
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (err_count == first_err) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, err_count - first_err);
		end
	endtask

	// Sends the command word and then the frame_buf words two cycles apart
	task automatic send_frame(input logic [7:0] cmd_code, input int n_words);
		@(posedge FPGA_CLK2_50);
		io_uio <= 1'b1;
		for (int i = 0; i <= n_words; i++) begin
			@(posedge FPGA_CLK2_50);
			io_strobe <= 1'b1;
			io_din <= (i == 0) ? {8'h00, cmd_code} : frame_buf[i-1];
			@(posedge FPGA_CLK2_50);
			io_strobe <= 1'b0;
		end
		@(posedge FPGA_CLK2_50);
		io_uio <= 1'b0;
	endtask

	// Own channel x plus a share of y on 32-bit integers
	function automatic logic [15:0] expected_blend(input logic [15:0] x, input logic [15:0] y,
			input int lvl, input logic s);
		int xi;
		int yi;
		int res;
		xi = s ? int'($signed(x)) : int'(x);
		yi = s ? int'($signed(y)) : int'(y);
		case (lvl)
			0: res = xi;
			1: res = xi - (xi >>> 3) + (yi >>> 3);
			2: res = xi - (xi >>> 2) + (yi >>> 2);
			default: res = (xi >>> 1) + (yi >>> 1);
		endcase
		return res[15:0];
	endfunction

	function automatic logic btn_out(input int chan);
		return (chan == 0) ? btn_user : btn_osd;
	endfunction

	// Channel 0 is user (key 1), channel 1 is OSD (key 0)
	task automatic drive_button(input int chan, input logic use_key, input logic level);
		if (chan == 0) begin
			if (use_key) key_n[1] <= level;
			else btn_user_n <= level;
		end else begin
			if (use_key) key_n[0] <= level;
			else btn_osd_n <= level;
		end
	endtask

	task automatic wait_button(input int chan, input logic level);
		bit seen;
		seen = 1'b0;
		for (int n = 0; n < DEB_BOUND && !seen; n++) begin
			@(posedge FPGA_CLK2_50);
			@(negedge FPGA_CLK2_50);
			if (btn_out(chan) === level) seen = 1'b1;
		end
		if (!seen) begin
			log_problem($sformatf("%s did not go to %0d within %0d cycles",
				(chan == 0) ? "btn_user" : "btn_osd", level, DEB_BOUND));
		end
	endtask

	// ==================================================
	// Tests
	// ==================================================
	task automatic timing_regs_update();
		logic [11:0] h_exp;
		logic [11:0] v_exp;
		first_err = err_count;
		if (width !== 12'd1280) value_error("width", 32'(width), 32'd1280);
		if (height !== 12'd720) value_error("height", 32'(height), 32'd720);
		if (h_total !== 12'd1650) value_error("h_total", 32'(h_total), 32'd1650);
		if (v_total !== 12'd750) value_error("v_total", 32'(v_total), 32'd750);
		for (int i = 0; i < 10; i++) begin
			frame_buf[i] = TIM_WORDS[i];
		end
		h_exp = frame_buf[0][11:0] + frame_buf[1][11:0] + frame_buf[2][11:0]
			+ frame_buf[3][11:0];
		v_exp = frame_buf[4][11:0] + frame_buf[5][11:0] + frame_buf[6][11:0]
			+ frame_buf[7][11:0];
		// Two words past the eighth must be dropped
		send_frame(8'h20, 10);
		@(negedge FPGA_CLK2_50);
		if (width !== frame_buf[0][11:0]) begin
			value_error("width", 32'(width), 32'(frame_buf[0][11:0]));
		end
		if (height !== frame_buf[4][11:0]) begin
			value_error("height", 32'(height), 32'(frame_buf[4][11:0]));
		end
		if (h_total !== h_exp) value_error("h_total", 32'(h_total), 32'(h_exp));
		if (v_total !== v_exp) value_error("v_total", 32'(v_total), 32'(v_exp));
		close_test("timing registers");
	endtask

	task automatic cfg_and_led_override();
		io_word_t   cfg_word;
		logic [15:0] ovr_word;
		logic       pwr_exp;
		logic [7:0] pattern;
		logic [7:0] led_exp;
		first_err = err_count;
		if (cfg_got !== 1'b0) value_error("cfg_got", 32'(cfg_got), 32'd0);
		cfg_word = 16'(rand_bits(16));
		frame_buf[0] = cfg_word;
		send_frame(8'h01, 1);
		@(negedge FPGA_CLK2_50);
		if (cfg !== cfg_word) value_error("cfg", 32'(cfg), 32'(cfg_word));
		if (cfg_got !== 1'b1) value_error("cfg_got", 32'(cfg_got), 32'd1);
		// Pass 0 runs with the reset mask of zero
		ovr_word = 16'h0000;
		for (int f = 0; f < 4; f++) begin
			if (f > 0) begin
				ovr_word = 16'(rand_bits(16));
				frame_buf[0] = ovr_word;
				send_frame(8'h25, 1);
			end
			for (int c = 0; c < 32; c++) begin
				@(posedge FPGA_CLK2_50);
				led_user <= c[0];
				led_power <= c[2:1];
				led_disk <= c[4:3];
				@(negedge FPGA_CLK2_50);
				pwr_exp = c[2] ? c[1] : 1'b1;
				// Power on bit 4, hdd on bit 2, user on bit 0
				pattern = '0;
				pattern[4] = pwr_exp;
				pattern[2] = c[3];
				pattern[0] = c[0];
				for (int b = 0; b < 8; b++) begin
					led_exp[b] = ovr_word[8 + b] ? ovr_word[b] : pattern[b];
				end
				if (led !== led_exp) value_error("led", 32'(led), 32'(led_exp));
				if (led_power_on !== pwr_exp) begin
					value_error("led_power_on", 32'(led_power_on), 32'(pwr_exp));
				end
				if (led_hdd_on !== c[3]) begin
					value_error("led_hdd_on", 32'(led_hdd_on), 32'(c[3]));
				end
				if (led_user_on !== c[0]) begin
					value_error("led_user_on", 32'(led_user_on), 32'(c[0]));
				end
			end
		end
		close_test("config and LED override");
	endtask

	task automatic audio_blend_levels();
		logic [15:0] samp_l;
		logic [15:0] samp_r;
		logic [15:0] exp_l;
		logic [15:0] exp_r;
		first_err = err_count;
		for (int lvl = 0; lvl < 4; lvl++) begin
			for (int s = 0; s < 2; s++) begin
				for (int k = 0; k < 6; k++) begin
					samp_l = 16'(rand_bits(16));
					samp_r = 16'(rand_bits(16));
					exp_l = expected_blend(samp_l, samp_r, lvl, s[0]);
					exp_r = expected_blend(samp_r, samp_l, lvl, s[0]);
					@(posedge FPGA_CLK2_50);
					audio_l <= samp_l;
					audio_r <= samp_r;
					amix <= 2'(lvl);
					audio_s <= s[0];
					@(posedge FPGA_CLK2_50);
					@(negedge FPGA_CLK2_50);
					if (mix_l !== exp_l) value_error("mix_l", 32'(mix_l), 32'(exp_l));
					if (mix_r !== exp_r) value_error("mix_r", 32'(mix_r), 32'(exp_r));
				end
			end
		end
		close_test("audio mixer");
	endtask

	task automatic debounce_buttons();
		bit glitch_seen;
		glitch_seen = 1'b0;
		first_err = err_count;
		if (btn_user !== 1'b0 || btn_osd !== 1'b0) begin
			log_problem("button outputs set after reset");
		end
		// Button then key, for user and then OSD
		for (int k = 0; k < 4; k++) begin
			@(posedge FPGA_CLK2_50);
			drive_button(k / 2, k[0], 1'b0);
			wait_button(k / 2, 1'b1);
			if (btn_out(1 - k / 2) !== 1'b0) log_problem("the other button output was set");
			@(posedge FPGA_CLK2_50);
			drive_button(k / 2, k[0], 1'b1);
			wait_button(k / 2, 1'b0);
		end
		@(posedge FPGA_CLK2_50);
		drive_button(0, 1'b0, 1'b0);
		for (int n = 1; n <= GLITCH_LEN + DEB_BOUND; n++) begin
			@(posedge FPGA_CLK2_50);
			if (n == GLITCH_LEN) drive_button(0, 1'b0, 1'b1);
			@(negedge FPGA_CLK2_50);
			if (btn_user !== 1'b0) glitch_seen = 1'b1;
		end
		if (glitch_seen) log_problem("btn_user set by a press shorter than eight ticks");
		close_test("button debounce");
	endtask

	task automatic reset_latch_sequence();
		first_err = err_count;
		if (reset_req !== 1'b0) value_error("reset_req", 32'(reset_req), 32'd0);
		@(posedge FPGA_CLK2_50);
		ctl_code <= 2'd1;
		@(posedge FPGA_CLK2_50);
		ctl_code <= 2'd3;
		@(negedge FPGA_CLK2_50);
		if (reset_req !== 1'b0) value_error("reset_req", 32'(reset_req), 32'd0);
		@(negedge FPGA_CLK2_50);
		if (reset_req !== 1'b1) value_error("reset_req", 32'(reset_req), 32'd1);
		// Code 2 after code 3 is not a release
		@(posedge FPGA_CLK2_50);
		ctl_code <= 2'd2;
		@(posedge FPGA_CLK2_50);
		ctl_code <= 2'd3;
		repeat (3) @(posedge FPGA_CLK2_50);
		@(negedge FPGA_CLK2_50);
		if (reset_req !== 1'b1) value_error("reset_req", 32'(reset_req), 32'd1);
		@(posedge FPGA_CLK2_50);
		ctl_code <= 2'd0;
		@(posedge FPGA_CLK2_50);
		ctl_code <= 2'd2;
		@(posedge FPGA_CLK2_50);
		ctl_code <= 2'd3;
		@(negedge FPGA_CLK2_50);
		if (reset_req !== 1'b1) value_error("reset_req", 32'(reset_req), 32'd1);
		@(negedge FPGA_CLK2_50);
		if (reset_req !== 1'b0) value_error("reset_req", 32'(reset_req), 32'd0);
		@(posedge FPGA_CLK2_50);
		btn_reset_n <= 1'b0;
		@(posedge FPGA_CLK2_50);
		btn_reset_n <= 1'b1;
		@(posedge FPGA_CLK2_50);
		@(negedge FPGA_CLK2_50);
		if (reset_req !== 1'b1) value_error("reset_req", 32'(reset_req), 32'd1);
		close_test("reset control");
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		resetd = 1'b1;
		io_uio = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
		// Code 3 is the idle code of the reset latch
		ctl_code = 2'd3;
		btn_user_n = 1'b1;
		btn_osd_n = 1'b1;
		btn_reset_n = 1'b1;
		key_n = 2'b11;
		led_user = 1'b0;
		led_power = 2'b00;
		led_disk = 2'b00;
		audio_l = '0;
		audio_r = '0;
		audio_s = 1'b0;
		amix = '0;
		repeat (5) @(posedge FPGA_CLK2_50);
		resetd <= 1'b0;
		@(posedge FPGA_CLK2_50);
		@(negedge FPGA_CLK2_50);
		timing_regs_update();
		cfg_and_led_override();
		audio_blend_levels();
		debounce_buttons();
		reset_latch_sequence();
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
		if (err_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: files.f
+incdir+include
logic/sys_pkg.sv
logic/hps_cmd_decoder.sv
logic/video_timing_regs.sv
logic/button_debounce.sv
logic/reset_control.sv
logic/led_control.sv
logic/audio_mixer.sv
logic/sys_top.sv
tests/sys_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
# The run counts as passed only if the testbench prints its pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f files.f \
	--top-module sys_top_tb -o sys_top_tb \
	&& ./obj_dir/sys_top_tb | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
